// File: bd_consts.svh
`ifndef BD_CONSTS_SVH
`define BD_CONSTS_SVH

// Pin word widths seen at the BD package pins
`define BD_DOWN_BITS 21 // Core to BD with route bit and payload
`define BD_UP_BITS 34 // BD to core and opaque to the bridge

// Payload carried by either downstream source
`define BD_PAYLOAD_BITS 20

// Default depth of each downstream queue
`define BD_FIFO_DEPTH 4

// Route bit sits in the top position of the downstream word
`define BD_ROUTE_CFG 1'b0 // Register write
`define BD_ROUTE_SPK 1'b1 // Neuron event

`endif

// File: bd_pkg.sv
`default_nettype none

`include "bd_consts.svh"

package bd_pkg;

    // Configuration write with the address on top
    typedef struct packed {
        logic [7:0]  addr; // Register address
        logic [11:0] data; // Register value
    } cfg_word_t;

    // Spike event for one neuron
    typedef struct packed {
        logic [15:0] neuron_id;
        logic [3:0]  count; // Events folded into this word
    } spk_word_t;

    // Word driven on the BD input pins
    typedef struct packed {
        logic                        route;   // BD_ROUTE_CFG or BD_ROUTE_SPK
        logic [`BD_PAYLOAD_BITS-1:0] payload; // cfg_word_t or spk_word_t bits
    } down_word_t;

    // Word read from the BD output pins and passed on untouched
    typedef logic [`BD_UP_BITS-1:0] up_word_t;

endpackage

`default_nettype wire

// File: chan_fifo.sv
`default_nettype none

`include "bd_consts.svh"

// Circular queue between two v/d/a channels
module chan_fifo #(
    parameter type payload_t = logic [`BD_PAYLOAD_BITS-1:0],
    parameter int  DEPTH     = `BD_FIFO_DEPTH
) (
    input  wire logic     clk,
    input  wire logic     reset,
    // Write side
    input  wire logic     in_v,
    input  wire payload_t in_d,
    output logic          in_a,
    // Read side
    output logic          out_v,
    output payload_t      out_d,
    input  wire logic     out_a
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH]; // Word storage
    logic     [PTR_W-1:0] wr_ptr;
    logic     [PTR_W-1:0] rd_ptr;
    logic     [CNT_W-1:0] count;      // Words currently held
    logic                 push;
    logic                 pop;

    assign in_a  = (count != CNT_W'(DEPTH)); // Room for one more
    assign out_v = (count != '0);
    assign out_d = mem[rd_ptr]; // Head word stays until popped

    assign push = in_v && in_a;
    assign pop  = out_v && out_a;

    // Payload write
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_d;
        end
    end

    // Pointers and count
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // Wrap at the last slot
                if (wr_ptr == PTR_W'(DEPTH - 1)) wr_ptr <= '0;
                else wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                if (rd_ptr == PTR_W'(DEPTH - 1)) rd_ptr <= '0;
                else rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave count as is
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: down_arbiter.sv
`default_nettype none

`include "bd_consts.svh"

// Round-robin merge of the config and spike queues onto one pin channel
module down_arbiter import bd_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    // Config queue head
    input  wire logic      cfg_v,
    input  wire cfg_word_t cfg_d,
    output logic           cfg_a,
    // Spike queue head
    input  wire logic      spk_v,
    input  wire spk_word_t spk_d,
    output logic           spk_a,
    // Merged channel to the pin controller
    output logic           arb_v,
    output down_word_t     arb_d,
    input  wire logic      arb_a
);

    logic last_route; // Route of the source served last
    logic grant_spk;  // Spike queue owns the channel this cycle

    // Spike wins if alone, or if both wait and config went last
    always_comb begin
        grant_spk = 1'b0;
        if (spk_v && !cfg_v) begin
            grant_spk = 1'b1;
        end else if (spk_v && cfg_v) begin
            grant_spk = (last_route == `BD_ROUTE_CFG);
        end
    end

    assign arb_v = cfg_v || spk_v;

    // Route code above the payload
    always_comb begin
        if (grant_spk) begin
            arb_d.route   = `BD_ROUTE_SPK;
            arb_d.payload = spk_d;
        end else begin
            arb_d.route   = `BD_ROUTE_CFG;
            arb_d.payload = cfg_d;
        end
    end

    // Acknowledge goes back to the granted queue only
    assign cfg_a = arb_a && !grant_spk;
    assign spk_a = arb_a && grant_spk;

    // Pointer flips to the source just served
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_route <= `BD_ROUTE_SPK; // Config goes first after reset
        end else if (arb_v && arb_a) begin
            last_route <= grant_spk ? `BD_ROUTE_SPK : `BD_ROUTE_CFG;
        end
    end

endmodule

`default_nettype wire

// File: pin_out_ctrl.sv
`default_nettype none

// Drives the BD input pins with level valid/ready sequencing
module pin_out_ctrl import bd_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    // Core side
    input  wire logic       arb_v,
    input  wire down_word_t arb_d,
    output logic            arb_a,
    // BD side
    output logic            pin_valid,
    output down_word_t      pin_data,
    input  wire logic       pin_ready
);

    typedef enum logic [1:0] {
        WAIT_INPUT, // Nothing loaded
        VALID_LOW,  // Data set up, valid still low
        VALID_HIGH  // BD may sample
    } state_t;

    state_t state;
    state_t next_state;
    logic   load; // Take arb_d into pin_data at this edge

    // Next state and load strobe
    always_comb begin
        next_state = state;
        load       = 1'b0;
        case (state)
            WAIT_INPUT: begin
                if (arb_v) begin
                    load       = 1'b1;
                    next_state = VALID_LOW;
                end
            end
            VALID_LOW: begin
                // Valid rises once the BD can read
                if (pin_ready) next_state = VALID_HIGH;
            end
            VALID_HIGH: begin
                // Falling ready ends the word
                if (!pin_ready) begin
                    if (arb_v) begin
                        load       = 1'b1; // Next word goes straight to setup
                        next_state = VALID_LOW;
                    end else begin
                        next_state = WAIT_INPUT;
                    end
                end
            end
            default: next_state = WAIT_INPUT;
        endcase
    end

    assign arb_a     = load;
    assign pin_valid = (state == VALID_HIGH); // Straight from the state flops

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= WAIT_INPUT;
        end else begin
            state <= next_state;
        end
    end

    // Changes only on load and never while valid is high with ready up
    always_ff @(posedge clk) begin
        if (load) begin
            pin_data <= arb_d;
        end
    end

endmodule

`default_nettype wire

// File: pin_in_ctrl.sv
`default_nettype none

// Latches BD output words onto a core channel
module pin_in_ctrl import bd_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    // BD side
    input  wire logic     bd_valid,
    input  wire up_word_t bd_data,
    output logic          bd_ready,
    // Core side
    output logic          up_v,
    output up_word_t      up_d,
    input  wire logic     up_a
);

    logic take;      // BD word sampled at this edge
    logic give;      // Core takes the held word at this edge
    logic full_next; // Holding register state after this edge

    // BD only offers while ready is high
    assign take = bd_valid && bd_ready;
    assign give = up_v && up_a;

    // up_v doubles as the full flag
    // Take and give never coincide since ready is low while full
    always_comb begin
        full_next = up_v;
        if (take) begin
            full_next = 1'b1;
        end else if (give) begin
            full_next = 1'b0;
        end
    end

    // Full flag and registered ready pin level
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            up_v     <= 1'b0;
            bd_ready <= 1'b1; // Empty so the BD may send
        end else begin
            up_v     <= full_next;
            bd_ready <= !full_next;
        end
    end

    // Holding register
    always_ff @(posedge clk) begin
        if (take) begin
            up_d <= bd_data; // Held under back-pressure
        end
    end

endmodule

`default_nettype wire

// File: bd_pin_bridge.sv
`default_nettype none

`include "bd_consts.svh"

// Pin-side bridge between core channels and the BD pins
module bd_pin_bridge import bd_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    // Config source
    input  wire logic      cfg_v,
    input  wire cfg_word_t cfg_d,
    output logic           cfg_a,
    // Spike source
    input  wire logic      spk_v,
    input  wire spk_word_t spk_d,
    output logic           spk_a,
    // BD input pins
    output logic           pin_valid,
    output down_word_t     pin_data,
    input  wire logic      pin_ready,
    // BD output pins
    input  wire logic      bd_valid,
    input  wire up_word_t  bd_data,
    output logic           bd_ready,
    // Upstream sink
    output logic           up_v,
    output up_word_t       up_d,
    input  wire logic      up_a
);

    // Queue heads toward the arbiter
    logic       cfg_q_v;
    cfg_word_t  cfg_q_d;
    logic       cfg_q_a;
    logic       spk_q_v;
    spk_word_t  spk_q_d;
    logic       spk_q_a;
    // Arbiter to pin controller
    logic       arb_v;
    down_word_t arb_d;
    logic       arb_a;

    chan_fifo #(.payload_t(cfg_word_t), .DEPTH(`BD_FIFO_DEPTH)) u_cfg_fifo (
        .clk(clk), .reset(reset),
        .in_v(cfg_v), .in_d(cfg_d), .in_a(cfg_a),
        .out_v(cfg_q_v), .out_d(cfg_q_d), .out_a(cfg_q_a)
    );

    chan_fifo #(.payload_t(spk_word_t), .DEPTH(`BD_FIFO_DEPTH)) u_spk_fifo (
        .clk(clk), .reset(reset),
        .in_v(spk_v), .in_d(spk_d), .in_a(spk_a),
        .out_v(spk_q_v), .out_d(spk_q_d), .out_a(spk_q_a)
    );

    down_arbiter u_down_arbiter (
        .clk(clk), .reset(reset),
        .cfg_v(cfg_q_v), .cfg_d(cfg_q_d), .cfg_a(cfg_q_a),
        .spk_v(spk_q_v), .spk_d(spk_q_d), .spk_a(spk_q_a),
        .arb_v(arb_v), .arb_d(arb_d), .arb_a(arb_a)
    );

    pin_out_ctrl u_pin_out_ctrl (
        .clk(clk), .reset(reset),
        .arb_v(arb_v), .arb_d(arb_d), .arb_a(arb_a),
        .pin_valid(pin_valid), .pin_data(pin_data), .pin_ready(pin_ready)
    );

    // Upstream path is a single stage
    pin_in_ctrl u_pin_in_ctrl (
        .clk(clk), .reset(reset),
        .bd_valid(bd_valid), .bd_data(bd_data), .bd_ready(bd_ready),
        .up_v(up_v), .up_d(up_d), .up_a(up_a)
    );

endmodule

`default_nettype wire

// File: tb_bd_pin_bridge.sv
`default_nettype none

`include "bd_consts.svh"

module tb_bd_pin_bridge import bd_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_DOWN_RAND  = 200; // Random phase with both sources
    localparam int NUM_RR         = 40;  // Stall plus round-robin phase
    localparam int NUM_UP         = 60;  // BD to core words
    localparam int TIMEOUT_CYCLES = (NUM_DOWN_RAND + NUM_RR + NUM_UP) * 12 + 500;
    localparam int DEPTH          = `BD_FIFO_DEPTH;
    localparam logic [31:0] SEED  = 32'd67;

    // DUT ports
    logic       clk;
    logic       reset;
    logic       cfg_v;
    cfg_word_t  cfg_d;
    logic       cfg_a;
    logic       spk_v;
    spk_word_t  spk_d;
    logic       spk_a;
    logic       pin_valid;
    down_word_t pin_data;
    logic       pin_ready;
    logic       bd_valid;
    up_word_t   bd_data;
    logic       bd_ready;
    logic       up_v;
    up_word_t   up_d;
    logic       up_a;

    // Phase control
    logic src_en   = 1'b0; // Sources may offer words
    logic src_rand = 1'b1; // Random gaps, else v held high
    logic down_en  = 1'b0; // BD reads its input pins
    logic up_en    = 1'b0; // BD sends upstream words
    logic rr_check = 1'b0; // Alternation is checked

    int cfg_sent = 0;
    int spk_sent = 0;
    int up_sent = 0;
    int delivered = 0;  // Words read by the BD
    int cycles = 0;
    int value_errors = 0;
    int other_errors = 0;
    int cfg_base;
    int spk_base;
    int bd_delay = 0;   // Cycles before the BD raises pin_ready again

    logic [31:0] rng_src  = SEED;
    logic [31:0] rng_bd   = SEED ^ 32'h9E37_79B9;
    logic [31:0] rng_up   = SEED ^ 32'h85EB_CA6B;
    logic [31:0] rng_sink = SEED ^ 32'hC2B2_AE35;

    logic [`BD_PAYLOAD_BITS-1:0] cfg_q [$]; // Expected config payloads
    logic [`BD_PAYLOAD_BITS-1:0] spk_q [$]; // Expected spike payloads
    up_word_t                    up_q  [$]; // Expected upstream words
    logic [`BD_PAYLOAD_BITS-1:0] exp_down;
    up_word_t                    exp_up;
    logic                        prev_valid = 1'b0;
    logic                        prev_ready = 1'b0;
    down_word_t                  prev_data;
    logic                        took = 1'b0; // BD word taken at the last edge
    up_word_t                    took_data;
    logic                        rr_seen = 1'b0;
    logic                        rr_last;

    bd_pin_bridge u_bd_pin_bridge (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        value_errors++;
        $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    endtask

    task automatic report_problem(input string what);
        other_errors++;
        $display("ERROR: %s", what);
    endtask

    task automatic print_error_counts();
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    endtask

    // Waits until the sources are idle and every scoreboard is empty
    task automatic wait_drained();
        do begin
            @(negedge clk); // Scoreboards settle between edges
        end while (cfg_v || spk_v || cfg_q.size() != 0 || spk_q.size() != 0 ||
                   up_sent < NUM_UP || up_q.size() != 0);
        repeat (8) @(posedge clk); // Pin stage back to idle
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Hard stop on a hung run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            report_problem("run did not finish before the cycle limit");
            print_error_counts();
            $display("Test failed");
            $finish;
        end
    end

    // Core sources hold v and d until accepted
    always @(posedge clk) begin
        if (cfg_v && cfg_a) begin
            cfg_q.push_back(cfg_d);
            cfg_sent <= cfg_sent + 1;
        end
        if (!cfg_v || cfg_a) begin
            rng_src = xorshift(rng_src);
            cfg_v <= src_en && (!src_rand || rng_src[1:0] != 2'd0);
            cfg_d <= cfg_word_t'(rng_src[31:12]);
        end
        if (spk_v && spk_a) begin
            spk_q.push_back(spk_d);
            spk_sent <= spk_sent + 1;
        end
        if (!spk_v || spk_a) begin
            rng_src = xorshift(rng_src);
            spk_v <= src_en && (!src_rand || rng_src[1:0] != 2'd0);
            spk_d <= spk_word_t'(rng_src[31:12]);
        end
    end

    // BD input pins drop ready once a word is sampled
    always @(posedge clk) begin
        if (!down_en) begin
            pin_ready <= 1'b0;
        end else if (pin_ready && pin_valid) begin
            pin_ready <= 1'b0;
            rng_bd = xorshift(rng_bd);
            bd_delay <= rng_bd % 6; // 0 to 5 cycles before the next word
        end else if (!pin_ready && !pin_valid) begin
            if (bd_delay == 0) pin_ready <= 1'b1;
            else bd_delay <= bd_delay - 1;
        end
    end

    // Delivered pin words against the per-source scoreboards
    always @(posedge clk) begin
        if (!rr_check) rr_seen = 1'b0;
        if (!reset && pin_valid && !pin_ready) begin
            delivered <= delivered + 1;
            if (pin_data.route == `BD_ROUTE_CFG) begin
                assert (cfg_q.size() != 0)
                    else report_problem("config word delivered with none outstanding");
                if (cfg_q.size() != 0) begin
                    exp_down = cfg_q.pop_front();
                    assert (pin_data.payload === exp_down)
                        else report_mismatch("pin_data.payload", pin_data.payload, exp_down);
                end
            end else begin
                assert (spk_q.size() != 0)
                    else report_problem("spike word delivered with none outstanding");
                if (spk_q.size() != 0) begin
                    exp_down = spk_q.pop_front();
                    assert (pin_data.payload === exp_down)
                        else report_mismatch("pin_data.payload", pin_data.payload, exp_down);
                end
            end
            if (rr_check && rr_seen)
                assert (pin_data.route !== rr_last)
                    else report_mismatch("pin_data.route", pin_data.route, !rr_last);
            rr_seen = rr_check;
            rr_last = pin_data.route;
        end
    end

    // Pin level rules
    always @(posedge clk) begin
        if (!reset) begin
            if (pin_valid && prev_valid)
                assert (pin_data === prev_data)
                    else report_mismatch("pin_data", pin_data, prev_data);
            if (pin_valid && !prev_valid)
                assert (prev_ready) else report_problem("pin_valid rose without pin_ready high");
        end
        prev_valid <= pin_valid;
        prev_ready <= pin_ready;
        prev_data  <= pin_data;
    end

    // BD output pins offer only while bd_ready is high
    always @(posedge clk) begin
        if (bd_valid && bd_ready) begin
            up_q.push_back(bd_data);
            up_sent  <= up_sent + 1;
            bd_valid <= 1'b0; // Ready is low from this edge on
        end else if (!bd_valid && bd_ready && up_en && up_sent < NUM_UP) begin
            rng_up = xorshift(rng_up);
            if (rng_up[1:0] != 2'd0) begin // Random gap between words
                bd_valid <= 1'b1;
                bd_data  <= {rng_up[3:2], xorshift(rng_up)};
            end
        end
    end

    always @(posedge clk) begin
        rng_sink = xorshift(rng_sink);
        up_a <= (rng_sink[1:0] != 2'd0); // Stall about one cycle in four
    end

    // Upstream timing and order
    always @(posedge clk) begin
        if (!reset) begin
            assert (bd_ready === !up_v) else report_mismatch("bd_ready", bd_ready, !up_v);
            if (took) begin
                assert (up_v === 1'b1) else report_mismatch("up_v", up_v, 1);
                assert (up_d === took_data) else report_mismatch("up_d", up_d, took_data);
            end
            if (up_v && up_a) begin
                assert (up_q.size() != 0)
                    else report_problem("upstream word delivered with none outstanding");
                if (up_q.size() != 0) begin
                    exp_up = up_q.pop_front();
                    assert (up_d === exp_up) else report_mismatch("up_d", up_d, exp_up);
                end
            end
        end
        took      <= bd_valid && bd_ready;
        took_data <= bd_data;
    end

    initial begin
        reset     = 1'b1;
        cfg_v     = 1'b0;
        cfg_d     = '0;
        spk_v     = 1'b0;
        spk_d     = '0;
        pin_ready = 1'b0;
        bd_valid  = 1'b0;
        bd_data   = '0;
        up_a      = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (pin_valid === 1'b0) else report_mismatch("pin_valid", pin_valid, 0);
        assert (up_v === 1'b0) else report_mismatch("up_v", up_v, 0);
        assert (bd_ready === 1'b1) else report_mismatch("bd_ready", bd_ready, 1);
        assert (cfg_a === 1'b1) else report_mismatch("cfg_a", cfg_a, 1);
        assert (spk_a === 1'b1) else report_mismatch("spk_a", spk_a, 1);

        // Random traffic both ways
        src_en  <= 1'b1;
        down_en <= 1'b1;
        up_en   <= 1'b1;
        while (cfg_sent + spk_sent < NUM_DOWN_RAND) @(posedge clk);
        src_en <= 1'b0;
        wait_drained();

        // BD stalled while both sources push every cycle
        down_en  <= 1'b0;
        src_rand <= 1'b0;
        repeat (3) @(posedge clk);
        cfg_base = cfg_sent;
        spk_base = spk_sent;
        src_en <= 1'b1;
        repeat (4 * DEPTH + 8) @(posedge clk);
        assert (cfg_sent + spk_sent - cfg_base - spk_base == 2 * DEPTH + 1)
            else report_mismatch("words accepted under stall",
                                 cfg_sent + spk_sent - cfg_base - spk_base, 2 * DEPTH + 1);
        assert (cfg_sent - cfg_base == DEPTH || cfg_sent - cfg_base == DEPTH + 1)
            else report_problem("config queue took an unexpected number of words under stall");
        assert (cfg_a === 1'b0) else report_mismatch("cfg_a", cfg_a, 0);
        assert (spk_a === 1'b0) else report_mismatch("spk_a", spk_a, 0);
        assert (pin_valid === 1'b0) else report_mismatch("pin_valid", pin_valid, 0);

        // BD resumes with both queues full
        rr_check <= 1'b1;
        down_en  <= 1'b1;
        while (cfg_sent + spk_sent < cfg_base + spk_base + NUM_RR) @(posedge clk);
        rr_check <= 1'b0;
        src_en   <= 1'b0;
        wait_drained();
        assert (delivered == cfg_sent + spk_sent)
            else report_mismatch("delivered words", delivered, cfg_sent + spk_sent);

        print_error_counts();
        if (value_errors + other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bd_pin_bridge.f
+incdir+.
bd_pkg.sv
chan_fifo.sv
down_arbiter.sv
pin_out_ctrl.sv
pin_in_ctrl.sv
bd_pin_bridge.sv
tb_bd_pin_bridge.sv

// File: Bender.yml
package:
  name: bd_pin_bridge

export_include_dirs:
  - .

sources:
  - files:
      - bd_pkg.sv
      - chan_fifo.sv
      - down_arbiter.sv
      - pin_out_ctrl.sv
      - pin_in_ctrl.sv
      - bd_pin_bridge.sv
  - target: test
    files:
      - tb_bd_pin_bridge.sv
